//--- list.f
+incdir+hw
hw/lc4_isa_pkg.sv
hw/lc4_fetch.sv
hw/lc4_regfile.sv
hw/lc4_decode.sv
hw/lc4_execute.sv
hw/lc4_mem_wb.sv
hw/lc4_core.sv
verif/lc4_core_chk.sv
verif/lc4_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := lc4_core_tb
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/lc4_core_tb.sv
`timescale 1ns/1ps
`include "lc4_consts.svh"

module lc4_core_tb;
    localparam int PROG_LEN = 200;
    // four cycles per instruction leaves room for stalls and flushes
    localparam int MAX_CYCLES = 4 * PROG_LEN + 50;
    localparam logic [15:0] PROG_END = 16'(`LC4_RESET_PC + PROG_LEN);

    logic        gwe;
    logic        i_reset;
    logic [15:0] i_imem_rdata;
    logic [15:0] i_dmem_rdata;
    logic [15:0] o_imem_addr;
    logic [15:0] o_dmem_addr;
    logic        o_dmem_we;
    logic [15:0] o_dmem_wdata;
    logic        o_retire_valid;
    logic [15:0] o_retire_pc;
    logic [15:0] o_retire_insn;
    logic        o_retire_rf_we;
    logic [2:0]  o_retire_rf_sel;
    logic [15:0] o_retire_rf_data;

    // program image, dut data memory and the model's own copy
    logic [15:0] prog [PROG_LEN];
    logic [15:0] dmem [logic [15:0]];
    logic [15:0] mmem [logic [15:0]];
    // architectural state of the reference model
    logic [15:0] mregs [8];
    logic [2:0]  mnzp;
    logic [15:0] mpc;
    // stores seen on the bus, waiting for their STR to retire
    logic [15:0] st_addr_q [$];
    logic [15:0] st_data_q [$];
    int          checks;
    int          mismatches;
    int          failures;
    int          retired;
    int          cycles;
    bit          done;

    lc4_core u_lc4_core (
        .gwe              (gwe),
        .i_reset          (i_reset),
        .i_imem_rdata     (i_imem_rdata),
        .i_dmem_rdata     (i_dmem_rdata),
        .o_imem_addr      (o_imem_addr),
        .o_dmem_addr      (o_dmem_addr),
        .o_dmem_we        (o_dmem_we),
        .o_dmem_wdata     (o_dmem_wdata),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_insn    (o_retire_insn),
        .o_retire_rf_we   (o_retire_rf_we),
        .o_retire_rf_sel  (o_retire_rf_sel),
        .o_retire_rf_data (o_retire_rf_data)
    );

    bind lc4_core lc4_core_chk u_chk (
        .gwe            (gwe),
        .i_reset        (i_reset),
        .i_imem_addr    (o_imem_addr),
        .i_dmem_we      (o_dmem_we),
        .i_retire_valid (o_retire_valid),
        .i_retire_rf_we (o_retire_rf_we)
    );

    always #5 gwe = ~gwe;

    // anything outside the program image reads as NOP
    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        if (addr >= `LC4_RESET_PC && addr < PROG_END) begin
            return prog[int'(addr) - int'(`LC4_RESET_PC)];
        end
        return `LC4_NOP;
    endfunction

    // untouched data words follow a pattern of the full address
    function automatic logic [15:0] fill_word(input logic [15:0] addr);
        return {addr[7:0], addr[15:8]} ^ 16'h3c5a;
    endfunction

    function automatic logic [15:0] dut_mem_read(input logic [15:0] addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [15:0] model_mem_read(input logic [15:0] addr);
        if (mmem.exists(addr)) begin
            return mmem[addr];
        end
        return fill_word(addr);
    endfunction

    task automatic check_val(input string name, input logic [15:0] exp_v,
                             input logic [15:0] got_v);
        checks++;
        assert (got_v === exp_v) else begin
            mismatches++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp_v, got_v);
        end
    endtask

    task automatic build_program();
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] last_rd;
        logic [2:0] st_base;
        logic [5:0] st_off;
        logic [5:0] off;
        int         kind;
        last_rd = 3'd0;
        st_base = 3'd0;
        st_off  = 6'd0;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = int'($urandom_range(11, 0));
            rd   = 3'($urandom_range(7, 0));
            rt   = 3'($urandom_range(7, 0));
            off  = 6'($urandom_range(63, 0));
            // half the sources come straight from the previous result
            rs = ($urandom_range(1, 0) == 0) ? last_rd : 3'($urandom_range(7, 0));
            case (kind)
                0: prog[i] = {`LC4_OP_ARITH, rd, rs, `LC4_SUB_ADD, rt};
                1: prog[i] = {`LC4_OP_ARITH, rd, rs, `LC4_SUB_SUB, rt};
                2: prog[i] = {`LC4_OP_ARITH, rd, rs, 1'b1, off[4:0]};
                3: prog[i] = {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_AND, rt};
                4: prog[i] = {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_OR, rt};
                5: prog[i] = {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_XOR, rt};
                6: prog[i] = {`LC4_OP_LOGIC, rd, rs, 1'b1, off[4:0]};
                7: prog[i] = {`LC4_OP_CONST, rd, 9'($urandom_range(511, 0))};
                8, 9: begin
                    // some loads revisit the last store address
                    if (kind == 9) begin
                        rs  = st_base;
                        off = st_off;
                    end
                    prog[i] = {`LC4_OP_LDR, rd, rs, off};
                end
                10: begin
                    // store data register in the rd slot, base random
                    prog[i] = {`LC4_OP_STR, rs, rt, off};
                    st_base = rt;
                    st_off  = off;
                end
                // short forward branch, non-empty mask
                default: prog[i] = {`LC4_OP_BR, 3'($urandom_range(7, 1)),
                                    9'($urandom_range(3, 0))};
            endcase
            if (kind < 10) begin
                last_rd = rd;
            end
        end
    endtask

    task automatic preload_data();
        logic [15:0] addr;
        logic [15:0] val;
        // window around zero, where CONST bases tend to land
        for (int i = 0; i < 256; i++) begin
            addr       = 16'(i - 128);
            val        = 16'($urandom);
            dmem[addr] = val;
            mmem[addr] = val;
        end
    endtask

    // ISA model, one instruction per retire event
    task automatic retire_step();
        logic [15:0] insn;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] addr;
        logic [15:0] nxt;
        logic [2:0]  rd;
        bit          we;
        insn = fetch_word(mpc);
        rd   = insn[11:9];
        a    = mregs[insn[8:6]];
        b    = mregs[insn[2:0]];
        res  = 16'h0000;
        addr = a + {{10{insn[5]}}, insn[5:0]};
        nxt  = mpc + 16'd1;
        we   = 1'b0;
        check_val("o_retire_pc", mpc, o_retire_pc);
        check_val("o_retire_insn", insn, o_retire_insn);
        case (insn[15:12])
            `LC4_OP_ARITH: begin
                we = 1'b1;
                if (insn[5]) begin
                    res = a + {{11{insn[4]}}, insn[4:0]};
                end else if (insn[5:3] == `LC4_SUB_SUB) begin
                    res = a - b;
                end else begin
                    res = a + b;
                end
            end
            `LC4_OP_LOGIC: begin
                we = 1'b1;
                if (insn[5]) begin
                    res = a & {{11{insn[4]}}, insn[4:0]};
                end else if (insn[5:3] == `LC4_SUB_OR) begin
                    res = a | b;
                end else if (insn[5:3] == `LC4_SUB_XOR) begin
                    res = a ^ b;
                end else begin
                    res = a & b;
                end
            end
            `LC4_OP_CONST: begin
                we  = 1'b1;
                res = {{7{insn[8]}}, insn[8:0]};
            end
            `LC4_OP_LDR: begin
                we  = 1'b1;
                res = model_mem_read(addr);
            end
            `LC4_OP_STR: begin
                assert (st_addr_q.size() != 0) else begin
                    failures++;
                    $display("STR at pc %h retired but never wrote data memory", mpc);
                end
                if (st_addr_q.size() != 0) begin
                    check_val("o_dmem_addr", addr, st_addr_q.pop_front());
                    check_val("o_dmem_wdata", mregs[rd], st_data_q.pop_front());
                end
                mmem[addr] = mregs[rd];
            end
            `LC4_OP_BR: begin
                // mask in the rd slot against the last condition code
                if ((rd & mnzp) != 3'b000) begin
                    nxt = mpc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
                end
            end
            default: begin
            end
        endcase
        check_val("o_retire_rf_we", {15'b0, we}, {15'b0, o_retire_rf_we});
        if (we) begin
            check_val("o_retire_rf_sel", {13'b0, rd}, {13'b0, o_retire_rf_sel});
            check_val("o_retire_rf_data", res, o_retire_rf_data);
            mregs[rd] = res;
            if (res[15]) begin
                mnzp = 3'b100;
            end else if (res == 16'h0000) begin
                mnzp = 3'b010;
            end else begin
                mnzp = 3'b001;
            end
        end
        mpc = nxt;
        retired++;
        if (mpc >= PROG_END) begin
            done = 1'b1;
        end
    endtask

    // outputs are settled mid-cycle, memories answer from here
    always @(negedge gwe) begin
        if (o_retire_valid && !done) begin
            retire_step();
        end
        // only one instruction sits in memory, so the store lands first
        if (o_dmem_we) begin
            st_addr_q.push_back(o_dmem_addr);
            st_data_q.push_back(o_dmem_wdata);
            dmem[o_dmem_addr] = o_dmem_wdata;
        end
        i_imem_rdata = fetch_word(o_imem_addr);
        i_dmem_rdata = dut_mem_read(o_dmem_addr);
    end

    initial begin
        void'($urandom(32'h67f6));
        gwe          = 1'b0;
        i_reset      = 1'b1;
        i_imem_rdata = `LC4_NOP;
        i_dmem_rdata = 16'h0000;
        checks       = 0;
        mismatches   = 0;
        failures     = 0;
        retired      = 0;
        cycles       = 0;
        done         = 1'b0;
        mpc          = `LC4_RESET_PC;
        mnzp         = 3'b000;
        for (int r = 0; r < 8; r++) begin
            mregs[r] = 16'h0000;
        end
        build_program();
        preload_data();
        repeat (2) @(posedge gwe);
        @(negedge gwe);
        i_reset = 1'b0;
        // first cycle out of reset
        check_val("o_imem_addr", `LC4_RESET_PC, o_imem_addr);
        check_val("o_retire_valid", 16'h0000, {15'b0, o_retire_valid});
        check_val("o_dmem_we", 16'h0000, {15'b0, o_dmem_we});
        while (!done && cycles < MAX_CYCLES) begin
            @(posedge gwe);
            cycles++;
        end
        assert (done) else begin
            failures++;
            $display("timeout after %0d cycles with %0d instructions retired", cycles, retired);
        end
        assert (st_addr_q.size() == 0) else begin
            failures++;
            $display("%0d data memory writes belong to no retired STR", st_addr_q.size());
        end
        failures += u_lc4_core.u_chk.fail_count;
        $display("checks %0d, mismatches %0d, other failures %0d, retired %0d, cycles %0d",
                 checks, mismatches, failures, retired, cycles);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verif/lc4_core_chk.sv
`timescale 1ns/1ps
`include "lc4_consts.svh"

module lc4_core_chk (
    input logic                 gwe,
    input logic                 i_reset,
    input logic [`LC4_XLEN-1:0] i_imem_addr,
    input logic                 i_dmem_we,
    input logic                 i_retire_valid,
    input logic                 i_retire_rf_we
);
    // pipeline registers hold no known value before the first reset edge
    logic seen_reset = 1'b0;
    int   fail_count = 0;

    always @(posedge gwe) begin
        if (i_reset) begin
            seen_reset <= 1'b1;
        end
    end

    // a register write only comes with a retiring instruction
    a_rf_we_valid: assert property (@(posedge gwe) disable iff (i_reset)
        i_retire_rf_we |-> i_retire_valid)
        else begin
            fail_count++;
            $error("retire write enable high without a retiring instruction");
        end

    a_no_store_in_reset: assert property (@(posedge gwe)
        (seen_reset && i_reset) |-> !i_dmem_we)
        else begin
            fail_count++;
            $error("data memory write while reset is asserted");
        end

    // fetch restarts at the reset vector
    a_reset_pc: assert property (@(posedge gwe)
        $fell(i_reset) |-> (i_imem_addr == `LC4_RESET_PC))
        else begin
            fail_count++;
            $error("first fetch after reset is not at the reset address");
        end

endmodule

//--- hw/lc4_core.sv
`timescale 1ns/1ps
`include "lc4_consts.svh"

module lc4_core (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  logic [`LC4_XLEN-1:0]   i_imem_rdata,
    input  logic [`LC4_XLEN-1:0]   i_dmem_rdata,
    output logic [`LC4_XLEN-1:0]   o_imem_addr,
    output logic [`LC4_XLEN-1:0]   o_dmem_addr,
    output logic                   o_dmem_we,
    output logic [`LC4_XLEN-1:0]   o_dmem_wdata,
    output logic                   o_retire_valid,
    output logic [`LC4_XLEN-1:0]   o_retire_pc,
    output logic [`LC4_XLEN-1:0]   o_retire_insn,
    output logic                   o_retire_rf_we,
    output logic [`LC4_RSEL_W-1:0] o_retire_rf_sel,
    output logic [`LC4_XLEN-1:0]   o_retire_rf_data
);
    import lc4_isa_pkg::*;

    // fetch to decode
    lc4_insn_u              d_insn;
    logic [`LC4_XLEN-1:0]   d_pc;
    logic                   d_valid;
    logic                   stall;
    logic                   redirect;
    logic [`LC4_XLEN-1:0]   redirect_pc;
    // decode to execute
    lc4_insn_u              x_insn;
    logic [`LC4_XLEN-1:0]   x_pc;
    logic                   x_valid;
    logic [`LC4_XLEN-1:0]   x_rs_data;
    logic [`LC4_XLEN-1:0]   x_rt_data;
    // execute to memory
    lc4_insn_u              m_insn;
    logic [`LC4_XLEN-1:0]   m_pc;
    logic                   m_valid;
    logic [`LC4_XLEN-1:0]   m_result;
    logic [`LC4_XLEN-1:0]   m_store_data;
    // bypass and writeback feedback
    logic [`LC4_RSEL_W-1:0] m_rd;
    logic                   m_rf_we;
    logic                   m_nzp_we;
    logic [`LC4_RSEL_W-1:0] wb_rd;
    logic                   wb_we;
    logic [`LC4_XLEN-1:0]   wb_data;
    logic                   wb_nzp_we;
    logic [2:0]             nzp;

    lc4_fetch u_fetch (
        .gwe           (gwe),
        .i_reset       (i_reset),
        .i_stall       (stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_imem_rdata  (i_imem_rdata),
        .o_imem_addr   (o_imem_addr),
        .o_d_insn      (d_insn),
        .o_d_pc        (d_pc),
        .o_d_valid     (d_valid)
    );

    lc4_decode u_decode (
        .gwe         (gwe),
        .i_reset     (i_reset),
        .i_d_insn    (d_insn),
        .i_d_pc      (d_pc),
        .i_d_valid   (d_valid),
        .i_flush     (redirect),
        .i_wb_rd     (wb_rd),
        .i_wb_data   (wb_data),
        .i_wb_we     (wb_we),
        .o_stall     (stall),
        .o_x_insn    (x_insn),
        .o_x_pc      (x_pc),
        .o_x_valid   (x_valid),
        .o_x_rs_data (x_rs_data),
        .o_x_rt_data (x_rt_data)
    );

    lc4_execute u_execute (
        .gwe            (gwe),
        .i_reset        (i_reset),
        .i_x_insn       (x_insn),
        .i_x_pc         (x_pc),
        .i_x_valid      (x_valid),
        .i_x_rs_data    (x_rs_data),
        .i_x_rt_data    (x_rt_data),
        .i_m_rd         (m_rd),
        .i_m_rf_we      (m_rf_we),
        .i_m_result     (m_result),
        .i_m_nzp_we     (m_nzp_we),
        .i_wb_rd        (wb_rd),
        .i_wb_we        (wb_we),
        .i_wb_data      (wb_data),
        .i_wb_nzp_we    (wb_nzp_we),
        .i_nzp          (nzp),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_m_insn       (m_insn),
        .o_m_pc         (m_pc),
        .o_m_valid      (m_valid),
        .o_m_result     (m_result),
        .o_m_store_data (m_store_data)
    );

    lc4_mem_wb u_mem_wb (
        .gwe              (gwe),
        .i_reset          (i_reset),
        .i_m_insn         (m_insn),
        .i_m_pc           (m_pc),
        .i_m_valid        (m_valid),
        .i_m_result       (m_result),
        .i_m_store_data   (m_store_data),
        .i_dmem_rdata     (i_dmem_rdata),
        .o_dmem_addr      (o_dmem_addr),
        .o_dmem_we        (o_dmem_we),
        .o_dmem_wdata     (o_dmem_wdata),
        .o_m_rd           (m_rd),
        .o_m_rf_we        (m_rf_we),
        .o_m_nzp_we       (m_nzp_we),
        .o_wb_rd          (wb_rd),
        .o_wb_we          (wb_we),
        .o_wb_data        (wb_data),
        .o_wb_nzp_we      (wb_nzp_we),
        .o_nzp            (nzp),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_insn    (o_retire_insn),
        .o_retire_rf_we   (o_retire_rf_we),
        .o_retire_rf_sel  (o_retire_rf_sel),
        .o_retire_rf_data (o_retire_rf_data)
    );

endmodule

//--- hw/lc4_mem_wb.sv
`timescale 1ns/1ps
`include "lc4_consts.svh"

module lc4_mem_wb (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  lc4_isa_pkg::lc4_insn_u i_m_insn,
    input  logic [`LC4_XLEN-1:0]   i_m_pc,
    input  logic                   i_m_valid,
    input  logic [`LC4_XLEN-1:0]   i_m_result,
    input  logic [`LC4_XLEN-1:0]   i_m_store_data,
    input  logic [`LC4_XLEN-1:0]   i_dmem_rdata,
    output logic [`LC4_XLEN-1:0]   o_dmem_addr,
    output logic                   o_dmem_we,
    output logic [`LC4_XLEN-1:0]   o_dmem_wdata,
    output logic [`LC4_RSEL_W-1:0] o_m_rd,
    output logic                   o_m_rf_we,
    output logic                   o_m_nzp_we,
    output logic [`LC4_RSEL_W-1:0] o_wb_rd,
    output logic                   o_wb_we,
    output logic [`LC4_XLEN-1:0]   o_wb_data,
    output logic                   o_wb_nzp_we,
    output logic [2:0]             o_nzp,
    output logic                   o_retire_valid,
    output logic [`LC4_XLEN-1:0]   o_retire_pc,
    output lc4_isa_pkg::lc4_insn_u o_retire_insn,
    output logic                   o_retire_rf_we,
    output logic [`LC4_RSEL_W-1:0] o_retire_rf_sel,
    output logic [`LC4_XLEN-1:0]   o_retire_rf_data
);
    import lc4_isa_pkg::*;

    logic                 is_load;
    logic                 is_store;
    logic                 writes_rf;
    logic [`LC4_XLEN-1:0] store_data;

    assign is_load  = i_m_valid && (i_m_insn.mem.opcode == `LC4_OP_LDR);
    assign is_store = i_m_valid && (i_m_insn.mem.opcode == `LC4_OP_STR);

    // every writer also sets nzp
    always_comb begin
        case (i_m_insn.rr.opcode)
            `LC4_OP_ARITH, `LC4_OP_LOGIC, `LC4_OP_LDR, `LC4_OP_CONST: writes_rf = 1'b1;
            default:                                                writes_rf = 1'b0;
        endcase
    end

    // destination sits in insn[11:9] for every writer
    assign o_m_rd = i_m_insn.rr.rd;

    assign o_m_rf_we  = i_m_valid && writes_rf;
    assign o_m_nzp_we = i_m_valid && writes_rf;

    // WM bypass, covers a load feeding the very next store
    assign store_data = (o_wb_we && o_wb_rd == i_m_insn.mem.rd) ? o_wb_data : i_m_store_data;

    assign o_dmem_addr  = (is_load || is_store) ? i_m_result : '0;
    assign o_dmem_we    = is_store;
    assign o_dmem_wdata = is_store ? store_data : '0;

    // memory/writeback register and condition codes
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_retire_valid <= 1'b0;
            o_retire_insn  <= `LC4_NOP;
            o_wb_we        <= 1'b0;
            o_wb_nzp_we    <= 1'b0;
            o_nzp          <= 3'b000;
        end else begin
            o_retire_valid <= i_m_valid;
            o_retire_insn  <= i_m_insn;
            o_wb_we        <= o_m_rf_we;
            o_wb_nzp_we    <= o_m_nzp_we;
            if (o_wb_nzp_we) begin
                o_nzp <= nzp_of(o_wb_data);
            end
        end
        o_retire_pc <= i_m_pc;
        o_wb_rd     <= o_m_rd;
        o_wb_data   <= is_load ? i_dmem_rdata : i_m_result;
    end

    // retire trace is the writeback stage as it stands
    assign o_retire_rf_we   = o_wb_we;
    assign o_retire_rf_sel  = o_wb_rd;
    assign o_retire_rf_data = o_wb_data;

endmodule

//--- hw/lc4_execute.sv
`timescale 1ns/1ps
`include "lc4_consts.svh"

module lc4_execute (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  lc4_isa_pkg::lc4_insn_u i_x_insn,
    input  logic [`LC4_XLEN-1:0]   i_x_pc,
    input  logic                   i_x_valid,
    input  logic [`LC4_XLEN-1:0]   i_x_rs_data,
    input  logic [`LC4_XLEN-1:0]   i_x_rt_data,
    input  logic [`LC4_RSEL_W-1:0] i_m_rd,
    input  logic                   i_m_rf_we,
    input  logic [`LC4_XLEN-1:0]   i_m_result,
    input  logic                   i_m_nzp_we,
    input  logic [`LC4_RSEL_W-1:0] i_wb_rd,
    input  logic                   i_wb_we,
    input  logic [`LC4_XLEN-1:0]   i_wb_data,
    input  logic                   i_wb_nzp_we,
    input  logic [2:0]             i_nzp,
    output logic                   o_redirect,
    output logic [`LC4_XLEN-1:0]   o_redirect_pc,
    output lc4_isa_pkg::lc4_insn_u o_m_insn,
    output logic [`LC4_XLEN-1:0]   o_m_pc,
    output logic                   o_m_valid,
    output logic [`LC4_XLEN-1:0]   o_m_result,
    output logic [`LC4_XLEN-1:0]   o_m_store_data
);
    import lc4_isa_pkg::*;

    logic [`LC4_RSEL_W-1:0] rs_sel;
    logic [`LC4_RSEL_W-1:0] rt_sel;
    logic [`LC4_XLEN-1:0]   rs_val;
    logic [`LC4_XLEN-1:0]   rt_val;
    logic [`LC4_XLEN-1:0]   imm5_sx;
    logic [`LC4_XLEN-1:0]   imm6_sx;
    logic [`LC4_XLEN-1:0]   imm9_sx;
    logic [`LC4_XLEN-1:0]   result;
    logic [2:0]             cur_nzp;

    // STR keeps its data register in the rd slot
    assign rs_sel = i_x_insn.rr.rs;
    assign rt_sel = (i_x_insn.mem.opcode == `LC4_OP_STR) ? i_x_insn.mem.rd : i_x_insn.rr.lo.r.rt;

    // MX first, then WX, else the value read in decode
    assign rs_val = (i_m_rf_we && i_m_rd == rs_sel)   ? i_m_result :
                    (i_wb_we && i_wb_rd == rs_sel)    ? i_wb_data :
                    i_x_rs_data;
    assign rt_val = (i_m_rf_we && i_m_rd == rt_sel)   ? i_m_result :
                    (i_wb_we && i_wb_rd == rt_sel)    ? i_wb_data :
                    i_x_rt_data;

    assign imm5_sx = {{(`LC4_XLEN-5){i_x_insn.rr.lo.i.imm5[4]}}, i_x_insn.rr.lo.i.imm5};
    assign imm6_sx = {{(`LC4_XLEN-6){i_x_insn.mem.imm6[5]}}, i_x_insn.mem.imm6};
    assign imm9_sx = {{(`LC4_XLEN-9){i_x_insn.br.imm9[8]}}, i_x_insn.br.imm9};

    always_comb begin
        result = '0;
        case (i_x_insn.rr.opcode)
            `LC4_OP_ARITH: begin
                if (i_x_insn.rr.lo.i.is_imm) begin
                    result = rs_val + imm5_sx;
                end else begin
                    case (i_x_insn.rr.lo.r.sub)
                        `LC4_SUB_ADD: result = rs_val + rt_val;
                        `LC4_SUB_SUB: result = rs_val - rt_val;
                        default:      result = '0;
                    endcase
                end
            end
            `LC4_OP_LOGIC: begin
                if (i_x_insn.rr.lo.i.is_imm) begin
                    result = rs_val & imm5_sx;
                end else begin
                    case (i_x_insn.rr.lo.r.sub)
                        `LC4_SUB_AND: result = rs_val & rt_val;
                        `LC4_SUB_OR:  result = rs_val | rt_val;
                        `LC4_SUB_XOR: result = rs_val ^ rt_val;
                        default:      result = '0;
                    endcase
                end
            end
            // effective address
            `LC4_OP_LDR, `LC4_OP_STR: result = rs_val + imm6_sx;
            `LC4_OP_CONST:            result = imm9_sx;
            default:                  result = '0;
        endcase
    end

    // youngest condition code, memory stage before writeback before register
    assign cur_nzp = i_m_nzp_we  ? nzp_of(i_m_result) :
                     i_wb_nzp_we ? nzp_of(i_wb_data) :
                     i_nzp;

    assign o_redirect    = i_x_valid && (i_x_insn.br.opcode == `LC4_OP_BR) &&
                           ((i_x_insn.br.nzp_rd & cur_nzp) != 3'b000);
    assign o_redirect_pc = i_x_pc + `LC4_XLEN'd1 + imm9_sx;

    // execute/memory register, nothing older than execute is ever squashed
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_m_valid <= 1'b0;
            o_m_insn  <= `LC4_NOP;
        end else begin
            o_m_valid <= i_x_valid;
            o_m_insn  <= i_x_insn;
        end
        o_m_pc         <= i_x_pc;
        o_m_result     <= result;
        o_m_store_data <= rt_val;
    end

endmodule

//--- hw/lc4_decode.sv
`timescale 1ns/1ps
`include "lc4_consts.svh"

module lc4_decode (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  lc4_isa_pkg::lc4_insn_u i_d_insn,
    input  logic [`LC4_XLEN-1:0]   i_d_pc,
    input  logic                   i_d_valid,
    input  logic                   i_flush,
    input  logic [`LC4_RSEL_W-1:0] i_wb_rd,
    input  logic [`LC4_XLEN-1:0]   i_wb_data,
    input  logic                   i_wb_we,
    output logic                   o_stall,
    output lc4_isa_pkg::lc4_insn_u o_x_insn,
    output logic [`LC4_XLEN-1:0]   o_x_pc,
    output logic                   o_x_valid,
    output logic [`LC4_XLEN-1:0]   o_x_rs_data,
    output logic [`LC4_XLEN-1:0]   o_x_rt_data
);
    logic [`LC4_RSEL_W-1:0] rs_sel;
    logic [`LC4_RSEL_W-1:0] rt_sel;
    logic                   rs_re;
    logic                   rt_re;
    logic                   is_cond_br;
    logic                   x_is_load;
    logic [`LC4_XLEN-1:0]   rs_data;
    logic [`LC4_XLEN-1:0]   rt_data;

    // source fields through the view the opcode selects
    always_comb begin
        rs_sel = i_d_insn.rr.rs;
        rt_sel = i_d_insn.rr.lo.r.rt;
        rs_re  = 1'b0;
        rt_re  = 1'b0;
        case (i_d_insn.rr.opcode)
            `LC4_OP_ARITH, `LC4_OP_LOGIC: begin
                rs_re = 1'b1;
                rt_re = !i_d_insn.rr.lo.i.is_imm;
            end
            `LC4_OP_LDR: begin
                rs_sel = i_d_insn.mem.rs;
                rs_re  = 1'b1;
            end
            `LC4_OP_STR: begin
                // store data is read here but only needed in memory,
                // where writeback can still supply it
                rs_sel = i_d_insn.mem.rs;
                rt_sel = i_d_insn.mem.rd;
                rs_re  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // a branch with an empty mask never looks at nzp
    assign is_cond_br = (i_d_insn.br.opcode == `LC4_OP_BR) && (i_d_insn.br.nzp_rd != 3'b000);
    assign x_is_load  = o_x_valid && (o_x_insn.mem.opcode == `LC4_OP_LDR);

    // load in execute, consumer or conditional branch in decode
    assign o_stall = i_d_valid && x_is_load &&
                     ((rs_re && rs_sel == o_x_insn.mem.rd) ||
                      (rt_re && rt_sel == o_x_insn.mem.rd) ||
                      is_cond_br);

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_rd_sel  (i_wb_rd),
        .i_rd_data (i_wb_data),
        .i_rd_we   (i_wb_we)
    );

    // decode/execute register, a stall or flush leaves a bubble behind
    always_ff @(posedge gwe) begin
        if (i_reset || i_flush || o_stall) begin
            o_x_valid <= 1'b0;
            o_x_insn  <= `LC4_NOP;
        end else begin
            o_x_valid <= i_d_valid;
            o_x_insn  <= i_d_insn;
        end
        o_x_pc      <= i_d_pc;
        o_x_rs_data <= rs_data;
        o_x_rt_data <= rt_data;
    end

endmodule

//--- hw/lc4_regfile.sv
`timescale 1ns/1ps
`include "lc4_consts.svh"

module lc4_regfile (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  logic [`LC4_RSEL_W-1:0] i_rs_sel,
    input  logic [`LC4_RSEL_W-1:0] i_rt_sel,
    output logic [`LC4_XLEN-1:0]   o_rs_data,
    output logic [`LC4_XLEN-1:0]   o_rt_data,
    input  logic [`LC4_RSEL_W-1:0] i_rd_sel,
    input  logic [`LC4_XLEN-1:0]   i_rd_data,
    input  logic                   i_rd_we
);
    logic [`LC4_XLEN-1:0] regs [`LC4_NREGS];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < `LC4_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // write-through, so decode sees what writeback stores this cycle
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

//--- hw/lc4_fetch.sv
`timescale 1ns/1ps
`include "lc4_consts.svh"

module lc4_fetch (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  logic                   i_stall,
    input  logic                   i_redirect,
    input  logic [`LC4_XLEN-1:0]   i_redirect_pc,
    input  lc4_isa_pkg::lc4_insn_u i_imem_rdata,
    output logic [`LC4_XLEN-1:0]   o_imem_addr,
    output lc4_isa_pkg::lc4_insn_u o_d_insn,
    output logic [`LC4_XLEN-1:0]   o_d_pc,
    output logic                   o_d_valid
);
    logic [`LC4_XLEN-1:0] pc;
    logic [`LC4_XLEN-1:0] next_pc;

    // redirect wins over a stall
    assign next_pc = i_redirect ? i_redirect_pc :
                     i_stall    ? pc :
                     pc + `LC4_XLEN'd1;

    // imem answers in the same cycle
    assign o_imem_addr = pc;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc <= `LC4_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // fetch/decode register
    always_ff @(posedge gwe) begin
        if (i_reset || i_redirect) begin
            o_d_valid <= 1'b0;
            o_d_insn  <= `LC4_NOP;
        end else if (!i_stall) begin
            o_d_valid <= 1'b1;
            o_d_insn  <= i_imem_rdata;
            o_d_pc    <= pc;
        end
    end

endmodule

//--- hw/lc4_isa_pkg.sv
`include "lc4_consts.svh"

package lc4_isa_pkg;

    // ALU format: ADD/SUB/AND/OR/XOR and their imm5 forms
    typedef struct packed {
        logic [3:0]            opcode;
        logic [2:0]            rd;
        logic [2:0]            rs;
        // low six bits are either sub-opcode plus rt or imm flag plus imm5
        union packed {
            struct packed {
                logic [2:0] sub;
                logic [2:0] rt;
            } r;
            struct packed {
                logic       is_imm;
                logic [4:0] imm5;
            } i;
        } lo;
    } lc4_rr_t;

    // LDR and STR, rd doubles as the store data source
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [5:0] imm6;
    } lc4_mem_t;

    // BR uses nzp_rd as the condition mask, CONST as the destination
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] nzp_rd;
        logic [8:0] imm9;
    } lc4_br_t;

    typedef union packed {
        lc4_rr_t  rr;
        lc4_mem_t mem;
        lc4_br_t  br;
    } lc4_insn_u;

    // one-hot condition code of a result
    function automatic logic [2:0] nzp_of(input logic [`LC4_XLEN-1:0] value);
        if (value[`LC4_XLEN-1]) begin
            return 3'b100;
        end
        return (value == '0) ? 3'b010 : 3'b001;
    endfunction

endpackage

//--- hw/lc4_consts.svh
`ifndef LC4_CONSTS_SVH
`define LC4_CONSTS_SVH

// datapath and address width
`define LC4_XLEN 16
// register select width and register count
`define LC4_RSEL_W 3
`define LC4_NREGS 8

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// major opcodes, insn[15:12]
`define LC4_OP_BR 4'h0
`define LC4_OP_ARITH 4'h1
`define LC4_OP_LOGIC 4'h5
`define LC4_OP_LDR 4'h6
`define LC4_OP_STR 4'h7
`define LC4_OP_CONST 4'h9

// sub-opcodes, insn[5:3]
// insn[5] set means the imm5 form, so every register form has it clear
`define LC4_SUB_ADD 3'b000
`define LC4_SUB_SUB 3'b010
`define LC4_SUB_AND 3'b000
`define LC4_SUB_OR 3'b010
`define LC4_SUB_XOR 3'b011

// BR with an empty condition, also the bubble word
`define LC4_NOP 16'h0000

`endif
